// File: hdl/issuePkg.sv
package issuePkg;

    localparam int TAG_W = 5;
    localparam int NUM_PREGS = 32;
    localparam int DATA_W = 32;
    localparam int SQN_W = 8;
    localparam int IQ_SIZE = 8;
    localparam int IQ_IDX_W = $clog2(IQ_SIZE);

    typedef logic [TAG_W-1:0] Tag;
    typedef logic [DATA_W-1:0] Data;
    typedef logic [SQN_W-1:0] SqN;

    typedef enum logic [2:0] {
        LI  = 3'd0,
        ADD = 3'd1,
        SUB = 3'd2,
        AND = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } OpCode;

    typedef struct packed {
        Tag    srcA;
        Tag    srcB;
        Tag    dst;
        OpCode opcode;
        Data   imm;
        logic  immB;
        SqN    sqN;
    } MicroOp;

    typedef struct packed {
        MicroOp op;
        logic   availA;
        logic   availB;
    } IqEntry;

    typedef struct packed {
        logic  valid;
        Tag    srcA;
        Tag    srcB;
        Tag    dst;
        OpCode opcode;
        Data   imm;
        logic  immB;
        SqN    sqN;
    } IssuedOp;

    typedef struct packed {
        logic valid;
        Tag   tag;
        Data  value;
        SqN   sqN;
    } ResultBus;

    typedef struct packed {
        logic valid;
        SqN   sqN;
    } BranchFlush;

    // Sequence numbers wrap, so age is the sign of the difference
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// File: hdl/dispatchStage.sv
module dispatchStage (
    input  logic                 clk,
    input  logic                 rst,
    input  issuePkg::MicroOp     inOp,
    input  logic                 inValid,
    output logic                 inReady,
    input  issuePkg::BranchFlush flush,
    input  issuePkg::ResultBus   resBus,
    output issuePkg::IqEntry     enqEntry,
    output logic                 dispValid,
    input  logic                 enqReady
);
    import issuePkg::*;

    logic [NUM_PREGS-1:0] busy;
    logic [NUM_PREGS-1:0] busyNext;
    logic started;
    logic accept;
    logic heldLeaves;
    logic heldFlushed;
    IqEntry newEntry;

    // Held back for one cycle after reset
    assign inReady = started && (!dispValid || enqReady);
    assign accept = inValid && inReady;
    assign heldLeaves = dispValid && enqReady;
    assign heldFlushed = flush.valid && isYounger(enqEntry.op.sqN, flush.sqN);

    // Lookup uses the scoreboard before this op's own destination is marked
    always_comb begin
        newEntry.op = inOp;
        newEntry.availA = !busy[inOp.srcA] || (resBus.valid && resBus.tag == inOp.srcA);
        newEntry.availB = !busy[inOp.srcB] || (resBus.valid && resBus.tag == inOp.srcB);
    end

    // A new writer of the broadcast tag keeps it pending
    always_comb begin
        busyNext = busy;
        if (resBus.valid) begin
            busyNext[resBus.tag] = 1'b0;
        end
        if (accept) begin
            busyNext[inOp.dst] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            dispValid <= 1'b0;
            busy <= '0;
        end else begin
            started <= 1'b1;
            busy <= busyNext;
            if (accept) begin
                dispValid <= 1'b1;
            end else if (heldLeaves || heldFlushed) begin
                dispValid <= 1'b0;
            end
        end
    end

    // Held op keeps picking up wakeups while the queue is busy
    always_ff @(posedge clk) begin
        if (accept) begin
            enqEntry <= newEntry;
        end else if (dispValid) begin
            enqEntry.availA <= enqEntry.availA
                || (resBus.valid && resBus.tag == enqEntry.op.srcA);
            enqEntry.availB <= enqEntry.availB
                || (resBus.valid && resBus.tag == enqEntry.op.srcB);
        end
    end

    // Holding register must never be overwritten before the queue takes it
    noOverwrite: assert property (@(posedge clk) disable iff (rst)
        (dispValid && !enqReady && !heldFlushed) |=> (dispValid && $stable(enqEntry.op)))
        else $error("op accepted while held op is blocked");

endmodule

// File: hdl/issueQueue.sv
module issueQueue (
    input  logic                 clk,
    input  logic                 rst,
    input  issuePkg::IqEntry     enqEntry,
    input  logic                 dispValid,
    output logic                 enqReady,
    input  issuePkg::ResultBus   resBus,
    input  issuePkg::BranchFlush flush,
    input  logic                 issueStall,
    output issuePkg::IssuedOp    issueOp
);
    import issuePkg::*;

    typedef logic [IQ_IDX_W:0] IqCount;

    IqEntry queue [IQ_SIZE];
    IqCount insertIdx;
    IqCount afterIssue;
    IqCount flushIdx;

    logic [IQ_SIZE-1:0] wakeA;
    logic [IQ_SIZE-1:0] wakeB;
    logic [IQ_SIZE-1:0] entryReady;
    logic selFound;
    logic [IQ_IDX_W-1:0] selIdx;
    logic [IQ_IDX_W-1:0] enqPos;
    logic doIssue;
    logic doEnq;
    IssuedOp selOp;
    IqEntry newEntry;

    assign enqReady = (insertIdx < IQ_SIZE) && !flush.valid;
    assign doEnq = dispValid && enqReady;
    assign doIssue = selFound && !issueStall && !flush.valid;

    // New entry goes behind the collapsed queue
    assign afterIssue = insertIdx - IqCount'(doIssue);
    assign enqPos = afterIssue[IQ_IDX_W-1:0];

    // Wakeup from the result broadcast
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            wakeA[i] = resBus.valid && resBus.tag == queue[i].op.srcA;
            wakeB[i] = resBus.valid && resBus.tag == queue[i].op.srcB;
            entryReady[i] = (i < insertIdx)
                && (queue[i].availA || wakeA[i])
                && (queue[i].availB || wakeB[i]);
        end
    end

    // Oldest ready entry, lowest index wins
    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (entryReady[i]) begin
                selFound = 1'b1;
                selIdx = IQ_IDX_W'(i);
            end
        end
    end

    always_comb begin
        selOp.valid = 1'b1;
        selOp.srcA = queue[selIdx].op.srcA;
        selOp.srcB = queue[selIdx].op.srcB;
        selOp.dst = queue[selIdx].op.dst;
        selOp.opcode = queue[selIdx].op.opcode;
        selOp.imm = queue[selIdx].op.imm;
        selOp.immB = queue[selIdx].op.immB;
        selOp.sqN = queue[selIdx].op.sqN;
    end

    // Incoming entry may be woken in the cycle it is written
    always_comb begin
        newEntry = enqEntry;
        newEntry.availA = enqEntry.availA
            || (resBus.valid && resBus.tag == enqEntry.op.srcA);
        newEntry.availB = enqEntry.availB
            || (resBus.valid && resBus.tag == enqEntry.op.srcB);
    end

    // Entries are age ordered, keep the prefix that is not younger
    always_comb begin
        flushIdx = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (i < insertIdx && !isYounger(queue[i].op.sqN, flush.sqN)) begin
                flushIdx = IqCount'(i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            queue[i].availA <= queue[i].availA || wakeA[i];
            queue[i].availB <= queue[i].availB || wakeB[i];
        end
        // Collapse the gap left by the issued entry
        if (doIssue) begin
            for (int j = 0; j < IQ_SIZE - 1; j++) begin
                if (j >= selIdx) begin
                    queue[j] <= queue[j + 1];
                    queue[j].availA <= queue[j + 1].availA || wakeA[j + 1];
                    queue[j].availB <= queue[j + 1].availB || wakeB[j + 1];
                end
            end
        end
        if (doEnq) begin
            queue[enqPos] <= newEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (doIssue) begin
            issueOp <= selOp;
        end
        if (rst) begin
            insertIdx <= '0;
            issueOp.valid <= 1'b0;
        end else if (flush.valid) begin
            insertIdx <= flushIdx;
            // Unstalled op was taken by the execution unit this edge
            if (!issueStall || isYounger(issueOp.sqN, flush.sqN)) begin
                issueOp.valid <= 1'b0;
            end
        end else begin
            insertIdx <= afterIssue + IqCount'(doEnq);
            if (!issueStall && !selFound) begin
                issueOp.valid <= 1'b0;
            end
        end
    end

    idxBound: assert property (@(posedge clk) disable iff (rst)
        insertIdx <= IQ_SIZE)
        else $error("insert index past end of queue");

    // A full queue keeps its youngest entry until something leaves
    noEnqFull: assert property (@(posedge clk) disable iff (rst)
        (insertIdx == IQ_SIZE && !doIssue && !flush.valid)
        |=> (insertIdx == IQ_SIZE && $stable(queue[IQ_SIZE-1].op)))
        else $error("enqueue into a full queue");

endmodule

// File: hdl/physRegFile.sv
module physRegFile (
    input  logic               clk,
    input  logic               rst,
    input  issuePkg::Tag       readTagA,
    input  issuePkg::Tag       readTagB,
    output issuePkg::Data      readDataA,
    output issuePkg::Data      readDataB,
    input  issuePkg::ResultBus resBus
);
    import issuePkg::*;

    Data regs [NUM_PREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (resBus.valid) begin
            regs[resBus.tag] <= resBus.value;
        end
    end

    // Same-cycle write is forwarded to the readers
    always_comb begin
        readDataA = regs[readTagA];
        readDataB = regs[readTagB];
        if (resBus.valid && resBus.tag == readTagA) begin
            readDataA = resBus.value;
        end
        if (resBus.valid && resBus.tag == readTagB) begin
            readDataB = resBus.value;
        end
    end

endmodule

// File: hdl/execUnit.sv
module execUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  issuePkg::IssuedOp    issueOp,
    output logic                 issueStall,
    output issuePkg::Tag         readTagA,
    output issuePkg::Tag         readTagB,
    input  issuePkg::Data        readDataA,
    input  issuePkg::Data        readDataB,
    input  issuePkg::BranchFlush flush,
    output issuePkg::ResultBus   resOut,
    output logic                 resValid,
    input  logic                 resReady,
    output issuePkg::ResultBus   resBus
);
    import issuePkg::*;

    IssuedOp s1Op;
    Data s1A;
    Data s1B;
    ResultBus s2Res;
    Data opB;
    Data aluOut;
    logic s2Accept;
    logic inKill;
    logic s1Kill;
    logic s2Kill;

    assign readTagA = issueOp.srcA;
    assign readTagB = issueOp.srcB;

    // Stage 2 moves when empty or draining
    assign s2Accept = !s2Res.valid || resReady;
    assign issueStall = s1Op.valid && !s2Accept;

    assign inKill = flush.valid && isYounger(issueOp.sqN, flush.sqN);
    assign s1Kill = flush.valid && isYounger(s1Op.sqN, flush.sqN);
    assign s2Kill = flush.valid && isYounger(s2Res.sqN, flush.sqN);

    assign opB = s1Op.immB ? s1Op.imm : s1B;

    always_comb begin
        case (s1Op.opcode)
            LI:      aluOut = s1Op.imm;
            ADD:     aluOut = s1A + opB;
            SUB:     aluOut = s1A - opB;
            AND:     aluOut = s1A & opB;
            XOR:     aluOut = s1A ^ opB;
            SLT:     aluOut = DATA_W'($signed(s1A) < $signed(opB));
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!issueStall) begin
            s1Op <= issueOp;
            s1A <= readDataA;
            s1B <= readDataB;
        end
        if (s2Accept) begin
            s2Res.tag <= s1Op.dst;
            s2Res.value <= aluOut;
            s2Res.sqN <= s1Op.sqN;
        end
        if (rst) begin
            s1Op.valid <= 1'b0;
            s2Res.valid <= 1'b0;
        end else begin
            if (!issueStall) begin
                s1Op.valid <= issueOp.valid && !inKill;
            end else if (s1Kill) begin
                s1Op.valid <= 1'b0;
            end
            if (s2Accept) begin
                s2Res.valid <= s1Op.valid && !s1Kill;
            end else if (s2Kill) begin
                s2Res.valid <= 1'b0;
            end
        end
    end

    assign resOut = s2Res;
    assign resValid = s2Res.valid;

    // Broadcast only on the transfer cycle
    always_comb begin
        resBus = s2Res;
        resBus.valid = s2Res.valid && resReady;
    end

    resStable: assert property (@(posedge clk) disable iff (rst)
        (resValid && !resReady && !s2Kill) |=> (resValid && $stable(resOut)))
        else $error("result changed while stalled");

endmodule

// File: hdl/issueTop.sv
module issueTop (
    input  logic                 clk,
    input  logic                 rst,
    input  issuePkg::MicroOp     inOp,
    input  logic                 inValid,
    output logic                 inReady,
    input  issuePkg::BranchFlush flush,
    output issuePkg::ResultBus   resOut,
    output logic                 resValid,
    input  logic                 resReady
);
    import issuePkg::*;

    IqEntry enqEntry;
    logic dispValid;
    logic enqReady;
    IssuedOp issueOp;
    logic issueStall;
    ResultBus resBus;
    Tag readTagA;
    Tag readTagB;
    Data readDataA;
    Data readDataB;

    dispatchStage dispatch0 (
        .clk(clk), .rst(rst),
        .inOp(inOp), .inValid(inValid), .inReady(inReady),
        .flush(flush), .resBus(resBus),
        .enqEntry(enqEntry), .dispValid(dispValid), .enqReady(enqReady)
    );

    issueQueue queue0 (
        .clk(clk), .rst(rst),
        .enqEntry(enqEntry), .dispValid(dispValid), .enqReady(enqReady),
        .resBus(resBus), .flush(flush),
        .issueStall(issueStall), .issueOp(issueOp)
    );

    physRegFile regFile0 (
        .clk(clk), .rst(rst),
        .readTagA(readTagA), .readTagB(readTagB),
        .readDataA(readDataA), .readDataB(readDataB),
        .resBus(resBus)
    );

    execUnit exec0 (
        .clk(clk), .rst(rst),
        .issueOp(issueOp), .issueStall(issueStall),
        .readTagA(readTagA), .readTagB(readTagB),
        .readDataA(readDataA), .readDataB(readDataB),
        .flush(flush),
        .resOut(resOut), .resValid(resValid), .resReady(resReady),
        .resBus(resBus)
    );

endmodule

// File: tb/issueTbTable.svh
`ifndef ISSUE_TB_TABLE_SVH
`define ISSUE_TB_TABLE_SVH

// Columns are isFlush, srcA, srcB, dst, opcode, imm, immB, sqN and expRes
// A flush row only uses sqN
// Flushed ops carry a zero expRes
typedef struct packed {
    logic  isFlush;
    Tag    srcA;
    Tag    srcB;
    Tag    dst;
    OpCode opcode;
    Data   imm;
    logic  immB;
    SqN    sqN;
    Data   expRes;
} StimRow;

localparam int NUM_ROWS = 31;

localparam StimRow STIMULUS [NUM_ROWS] = '{
    // Basic ALU ops with register and immediate operands
    '{1'b0, 5'd0, 5'd0, 5'd1, LI, 32'h0000_0064, 1'b0, 8'd1, 32'h0000_0064},
    '{1'b0, 5'd0, 5'd0, 5'd2, LI, 32'hFFFF_FFF9, 1'b0, 8'd2, 32'hFFFF_FFF9},
    '{1'b0, 5'd1, 5'd2, 5'd3, ADD, 32'h0000_0000, 1'b0, 8'd3, 32'h0000_005D},
    '{1'b0, 5'd1, 5'd2, 5'd4, SUB, 32'h0000_0000, 1'b0, 8'd4, 32'h0000_006B},
    '{1'b0, 5'd1, 5'd0, 5'd5, AND, 32'h0000_000F, 1'b1, 8'd5, 32'h0000_0004},
    '{1'b0, 5'd2, 5'd0, 5'd6, XOR, 32'h0000_00FF, 1'b1, 8'd6, 32'hFFFF_FF06},
    '{1'b0, 5'd2, 5'd1, 5'd7, SLT, 32'h0000_0000, 1'b0, 8'd7, 32'h0000_0001},
    '{1'b0, 5'd1, 5'd0, 5'd8, SLT, 32'hFFFF_FF38, 1'b1, 8'd8, 32'h0000_0000},
    '{1'b0, 5'd2, 5'd0, 5'd9, SUB, 32'h0000_0005, 1'b1, 8'd9, 32'hFFFF_FFF4},
    '{1'b0, 5'd9, 5'd2, 5'd10, SLT, 32'h0000_0000, 1'b0, 8'd10, 32'h0000_0001},
    // Pending pair followed by independent younger ops
    '{1'b0, 5'd0, 5'd0, 5'd11, LI, 32'h0000_1234, 1'b0, 8'd11, 32'h0000_1234},
    '{1'b0, 5'd11, 5'd11, 5'd12, ADD, 32'h0000_0000, 1'b0, 8'd12, 32'h0000_2468},
    '{1'b0, 5'd12, 5'd1, 5'd13, XOR, 32'h0000_0000, 1'b0, 8'd13, 32'h0000_240C},
    '{1'b0, 5'd0, 5'd0, 5'd14, LI, 32'h0000_0055, 1'b0, 8'd14, 32'h0000_0055},
    '{1'b0, 5'd4, 5'd0, 5'd15, AND, 32'h0000_0003, 1'b1, 8'd15, 32'h0000_0003},
    // Back to back dependency chain
    '{1'b0, 5'd14, 5'd0, 5'd16, ADD, 32'h0000_0001, 1'b1, 8'd16, 32'h0000_0056},
    '{1'b0, 5'd16, 5'd0, 5'd17, ADD, 32'h0000_0001, 1'b1, 8'd17, 32'h0000_0057},
    '{1'b0, 5'd17, 5'd0, 5'd18, ADD, 32'h0000_0001, 1'b1, 8'd18, 32'h0000_0058},
    '{1'b0, 5'd18, 5'd0, 5'd19, ADD, 32'h0000_0001, 1'b1, 8'd19, 32'h0000_0059},
    '{1'b0, 5'd19, 5'd0, 5'd20, ADD, 32'h0000_0001, 1'b1, 8'd20, 32'h0000_005A},
    '{1'b0, 5'd20, 5'd0, 5'd21, ADD, 32'h0000_0001, 1'b1, 8'd21, 32'h0000_005B},
    '{1'b0, 5'd21, 5'd0, 5'd22, ADD, 32'h0000_0001, 1'b1, 8'd22, 32'h0000_005C},
    '{1'b0, 5'd22, 5'd0, 5'd23, ADD, 32'h0000_0001, 1'b1, 8'd23, 32'h0000_005D},
    '{1'b0, 5'd23, 5'd0, 5'd24, ADD, 32'h0000_0001, 1'b1, 8'd24, 32'h0000_005E},
    '{1'b0, 5'd24, 5'd0, 5'd25, ADD, 32'h0000_0001, 1'b1, 8'd25, 32'h0000_005F},
    // Branch at sqN 26 with two younger ops behind it
    '{1'b0, 5'd25, 5'd13, 5'd26, ADD, 32'h0000_0000, 1'b0, 8'd26, 32'h0000_246B},
    '{1'b0, 5'd0, 5'd0, 5'd27, LI, 32'h0000_0077, 1'b0, 8'd27, 32'h0000_0000},
    '{1'b0, 5'd26, 5'd0, 5'd28, ADD, 32'h0000_0001, 1'b1, 8'd28, 32'h0000_0000},
    '{1'b1, 5'd0, 5'd0, 5'd0, LI, 32'h0000_0000, 1'b0, 8'd26, 32'h0000_0000},
    // Tag 27 rewritten after the flush, then read
    '{1'b0, 5'd0, 5'd0, 5'd27, LI, 32'h0000_0099, 1'b0, 8'd29, 32'h0000_0099},
    '{1'b0, 5'd27, 5'd26, 5'd29, ADD, 32'h0000_0000, 1'b0, 8'd30, 32'h0000_2504}
};

`endif

// File: tb/issueTb.sv
module issueTb;
    timeunit 1ns;
    timeprecision 100ps;

    import issuePkg::*;

    `include "issueTbTable.svh"

    localparam int WAIT_LIMIT = 300;
    localparam int NUM_SQN = 2 ** SQN_W;

    logic clk;
    logic rst;
    MicroOp inOp;
    logic inValid;
    logic inReady;
    BranchFlush flush;
    ResultBus resOut;
    logic resValid;
    logic resReady;

    int seed = 32'h124652ce;
    bit holdRes;
    bit aborted;
    int valueErrors = 0;
    int otherErrors = 0;
    int timeouts = 0;
    int liveTotal = 0;
    int sentLive = 0;
    int doneCount = 0;
    int lateCount = 0;
    int maxSeen = 0;
    Data expValue [NUM_SQN];
    Tag expTag [NUM_SQN];
    bit expValid [NUM_SQN];
    bit seen [NUM_SQN];
    bit flushedRow [NUM_ROWS];

    issueTop dut0 (
        .clk(clk), .rst(rst),
        .inOp(inOp), .inValid(inValid), .inReady(inReady),
        .flush(flush),
        .resOut(resOut), .resValid(resValid), .resReady(resReady)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Nonzero difference with a clear top bit means a is younger than b
    function automatic bit youngerThan(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return (diff != '0) && !diff[SQN_W-1];
    endfunction

    function automatic Data expectedValue(input OpCode opc, input Data a, input Data b,
                                          input Data imm);
        case (opc)
            LI:      return imm;
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // Program-order model over a mirror of the physical registers
    task automatic buildExpected();
        Data mirror [NUM_PREGS];
        Data a;
        Data b;
        Data r;
        for (int p = 0; p < NUM_PREGS; p++) begin
            mirror[p] = '0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            flushedRow[i] = 1'b0;
            for (int j = i + 1; j < NUM_ROWS; j++) begin
                if (STIMULUS[j].isFlush && !STIMULUS[i].isFlush
                    && youngerThan(STIMULUS[i].sqN, STIMULUS[j].sqN)) begin
                    flushedRow[i] = 1'b1;
                end
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (!STIMULUS[i].isFlush && !flushedRow[i]) begin
                a = mirror[STIMULUS[i].srcA];
                b = STIMULUS[i].immB ? STIMULUS[i].imm : mirror[STIMULUS[i].srcB];
                r = expectedValue(STIMULUS[i].opcode, a, b, STIMULUS[i].imm);
                mirror[STIMULUS[i].dst] = r;
                expValue[STIMULUS[i].sqN] = r;
                expTag[STIMULUS[i].sqN] = STIMULUS[i].dst;
                expValid[STIMULUS[i].sqN] = 1'b1;
                liveTotal++;
                assert (r == STIMULUS[i].expRes) else begin
                    $display("CHECK FAILED %0t: expRes of sqN %0d: model %h table %h",
                             $time, STIMULUS[i].sqN, r, STIMULUS[i].expRes);
                    valueErrors++;
                end
            end
        end
    endtask

    // Advance past the next rising edge and redrive resReady
    task automatic stepCycle();
        int r;
        @(posedge clk);
        #1;
        r = $random(seed);
        resReady = holdRes ? 1'b0 : (r[1:0] != 2'b00);
    endtask

    task automatic waitOutstanding(input int limit);
        int waits;
        waits = 0;
        while (sentLive - doneCount > limit && !aborted) begin
            stepCycle();
            waits++;
            if (waits >= WAIT_LIMIT) begin
                $display("Timeout: %0d results still missing", sentLive - doneCount);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic applyRow(input int i);
        int waits;
        if (STIMULUS[i].isFlush) begin
            flush.valid = 1'b1;
            flush.sqN = STIMULUS[i].sqN;
            stepCycle();
            flush = '0;
            holdRes = 1'b0;
        end else begin
            // Results stay held until the flush so no younger op can finish
            if (flushedRow[i] && !holdRes) begin
                waitOutstanding(4);
                holdRes = 1'b1;
            end
            inOp.srcA = STIMULUS[i].srcA;
            inOp.srcB = STIMULUS[i].srcB;
            inOp.dst = STIMULUS[i].dst;
            inOp.opcode = STIMULUS[i].opcode;
            inOp.imm = STIMULUS[i].imm;
            inOp.immB = STIMULUS[i].immB;
            inOp.sqN = STIMULUS[i].sqN;
            inValid = !aborted;
            waits = 0;
            while (!inReady && !aborted) begin
                stepCycle();
                waits++;
                if (waits >= WAIT_LIMIT) begin
                    $display("Timeout: op sqN %0d was never accepted", STIMULUS[i].sqN);
                    timeouts++;
                    aborted = 1'b1;
                end
            end
            if (!aborted) begin
                stepCycle();
                if (!flushedRow[i]) begin
                    sentLive++;
                end
            end
            inValid = 1'b0;
        end
    endtask

    task automatic checkResult(input ResultBus res);
        SqN s;
        s = res.sqN;
        if (int'(s) < maxSeen) begin
            lateCount++;
        end else begin
            maxSeen = int'(s);
        end
        assert (res.valid) else begin
            $display("CHECK FAILED %0t: resOut.valid of sqN %0d: got %b expected 1",
                     $time, s, res.valid);
            valueErrors++;
        end
        assert (expValid[s]) else begin
            $display("%0t: result for sqN %0d, which was flushed or never sent", $time, s);
            otherErrors++;
        end
        if (expValid[s]) begin
            assert (!seen[s]) else begin
                $display("%0t: second result for sqN %0d", $time, s);
                otherErrors++;
            end
            if (!seen[s]) begin
                seen[s] = 1'b1;
                doneCount++;
            end
            assert (res.tag == expTag[s]) else begin
                $display("CHECK FAILED %0t: resOut.tag of sqN %0d: got %0d expected %0d",
                         $time, s, res.tag, expTag[s]);
                valueErrors++;
            end
            assert (res.value == expValue[s]) else begin
                $display("CHECK FAILED %0t: resOut.value of sqN %0d: got %h expected %h",
                         $time, s, res.value, expValue[s]);
                valueErrors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && resValid && resReady) begin
            checkResult(resOut);
        end
    end

    initial begin
        rst = 1'b1;
        inOp = '0;
        inValid = 1'b0;
        flush = '0;
        resReady = 1'b0;
        holdRes = 1'b0;
        aborted = 1'b0;
        for (int s = 0; s < NUM_SQN; s++) begin
            expValid[s] = 1'b0;
            seen[s] = 1'b0;
        end
        buildExpected();
        stepCycle();
        stepCycle();
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
            applyRow(i);
        end
        waitOutstanding(0);
        // Window for stray results from flushed ops
        repeat (10) stepCycle();
        for (int s = 0; s < NUM_SQN; s++) begin
            if (expValid[s]) begin
                assert (seen[s]) else begin
                    $display("No result arrived for sqN %0d", s);
                    otherErrors++;
                end
            end
        end
        // Independent ops behind pending ones must overtake them
        assert (lateCount > 0) else begin
            $display("No result arrived out of program order");
            otherErrors++;
        end
        $display("%0d of %0d results, %0d out of program order", doneCount, liveTotal,
                 lateCount);
        $display("Errors: %0d value, %0d result stream, %0d timeout", valueErrors,
                 otherErrors, timeouts);
        if (valueErrors == 0 && otherErrors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+tb
hdl/issuePkg.sv
hdl/dispatchStage.sv
hdl/issueQueue.sv
hdl/physRegFile.sv
hdl/execUnit.sv
hdl/issueTop.sv
tb/issueTb.sv

// File: Bender.yml
package:
  name: issue_subsystem

sources:
  - files:
      - hdl/issuePkg.sv
      - hdl/dispatchStage.sv
      - hdl/issueQueue.sv
      - hdl/physRegFile.sv
      - hdl/execUnit.sv
      - hdl/issueTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/issueTb.sv
